// ==== include/dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// cache geometry
`define DC_WAYS 2
`define DC_SETS 16
`define DC_INDEX_W 4
`define DC_WORDS 4

// address split: tag [30:8], index [7:4], byte offset [3:0]
`define DC_OFFSET_W 4
`define DC_TAG_W 23
`define DC_UNC_BIT 31

// bus length field for a four-beat line burst
`define DC_BURST_LEN 3

`endif

// ==== logic/dcache_pkg.sv ====
`include "dcache_consts.svh"

package dcache_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0] strb_t;
    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [`DC_INDEX_W-1:0] index_t;
    typedef logic [1:0] word_sel_t;
    typedef logic way_t;
    typedef word_t [`DC_WORDS-1:0] line_t; // word 0 in the low bits

    // processor request as held for the whole access
    typedef struct packed {
        logic write;
        logic uncached;
        tag_t tag;
        index_t index;
        word_sel_t word_sel;
        addr_t addr;
        word_t wdata;
        strb_t strb;
    } cpu_req_t;

    // one burst or single transfer for the bus engine
    typedef struct packed {
        logic read;
        logic single;  // one beat, length 0
        addr_t addr;
        line_t wline;  // write-back data
        word_t wdata;  // uncached store data
        strb_t strb;
    } bus_cmd_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITE_BACK,
        REFILL,
        UNCACHED,
        RESPOND
    } ctrl_state_t;

endpackage

// ==== logic/cpu_req_capture.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module cpu_req_capture (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_write,
    input dcache_pkg::addr_t req_addr,
    input dcache_pkg::word_t req_wdata,
    input dcache_pkg::strb_t req_strb,
    output logic req_go,
    output dcache_pkg::cpu_req_t req
);
    import dcache_pkg::*;

    tag_t addr_tag;
    index_t addr_index;
    word_sel_t addr_word;

    // bit 31 is left out of the tag so both aliases name one word
    assign addr_tag = req_addr[`DC_OFFSET_W + `DC_INDEX_W +: `DC_TAG_W];
    assign addr_index = req_addr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign addr_word = req_addr[`DC_OFFSET_W-1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            req_go <= 1'b0;
        end else begin
            req_go <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            req.write <= req_write;
            req.uncached <= req_addr[`DC_UNC_BIT];
            req.tag <= addr_tag;
            req.index <= addr_index;
            req.word_sel <= addr_word;
            req.addr <= req_addr;
            req.wdata <= req_wdata;
            req.strb <= req_strb;
        end
    end

endmodule

// ==== logic/dcache_arrays.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_arrays (
    input logic clk,
    input logic rst,
    input dcache_pkg::index_t index,
    input dcache_pkg::tag_t tag,
    input logic fill_en,
    input dcache_pkg::word_sel_t fill_word,
    input dcache_pkg::word_t fill_data,
    input dcache_pkg::way_t fill_way,
    input logic store_en,
    input dcache_pkg::word_sel_t store_word,
    input dcache_pkg::word_t store_data,
    input dcache_pkg::strb_t store_strb,
    input dcache_pkg::way_t store_way,
    input logic touch_en,
    input dcache_pkg::way_t touch_way,
    output logic hit,
    output dcache_pkg::way_t hit_way,
    output dcache_pkg::line_t hit_line,
    output dcache_pkg::way_t victim_way,
    output logic victim_dirty,
    output dcache_pkg::tag_t victim_tag,
    output dcache_pkg::line_t victim_line
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid_q [`DC_WAYS];
    logic [`DC_SETS-1:0] lru_q;  // way to evict next, per set
    logic dirty_q [`DC_WAYS][`DC_SETS];
    tag_t tag_q [`DC_WAYS][`DC_SETS];
    line_t data_q [`DC_WAYS][`DC_SETS];
    logic [`DC_WAYS-1:0] match;
    logic fill_last;

    always_comb begin
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_q[w][index] && (tag_q[w][index] == tag);
        end
    end

    assign hit = |match;
    assign hit_way = way_t'(match[1]); // one-hot to way number
    assign hit_line = data_q[hit_way][index];

    assign victim_way = lru_q[index];
    assign victim_dirty = valid_q[victim_way][index] && dirty_q[victim_way][index];
    assign victim_tag = tag_q[victim_way][index];
    assign victim_line = data_q[victim_way][index];

    assign fill_last = fill_en && (fill_word == word_sel_t'(`DC_WORDS-1));

    always_ff @(posedge clk) begin
        if (rst) begin
            lru_q <= '0;
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            if (fill_last) begin
                valid_q[fill_way][index] <= 1'b1;
            end
            if (touch_en) begin
                lru_q[index] <= ~touch_way; // point away from the used way
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[fill_way][index][fill_word] <= fill_data;
        end
        // line comes in clean, a store miss dirties it a cycle later
        if (fill_last) begin
            tag_q[fill_way][index] <= tag;
            dirty_q[fill_way][index] <= 1'b0;
        end
        if (store_en) begin
            dirty_q[store_way][index] <= 1'b1;
            for (int b = 0; b < 4; b++) begin
                if (store_strb[b]) begin
                    data_q[store_way][index][store_word][8*b +: 8] <= store_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module dcache_ctrl (
    input logic clk,
    input logic rst,
    input logic req_go,
    input dcache_pkg::cpu_req_t req,
    input logic hit,
    input dcache_pkg::way_t hit_way,
    input dcache_pkg::line_t hit_line,
    input dcache_pkg::way_t victim_way,
    input logic victim_dirty,
    input dcache_pkg::tag_t victim_tag,
    input dcache_pkg::line_t victim_line,
    input logic cmd_done,
    input logic beat_valid,
    input dcache_pkg::word_sel_t beat_num,
    input dcache_pkg::word_t beat_data,
    output logic busy,
    output logic rsp_valid,
    output dcache_pkg::word_t rsp_rdata,
    output dcache_pkg::index_t index,
    output dcache_pkg::tag_t tag,
    output logic fill_en,
    output dcache_pkg::word_sel_t fill_word,
    output dcache_pkg::word_t fill_data,
    output dcache_pkg::way_t fill_way,
    output logic store_en,
    output dcache_pkg::word_sel_t store_word,
    output dcache_pkg::word_t store_data,
    output dcache_pkg::strb_t store_strb,
    output dcache_pkg::way_t store_way,
    output logic touch_en,
    output dcache_pkg::way_t touch_way,
    output logic cmd_go,
    output dcache_pkg::bus_cmd_t cmd
);
    import dcache_pkg::*;

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    word_t rdata_q;  // miss or uncached load result
    bus_cmd_t refill_cmd;
    bus_cmd_t wb_cmd;
    bus_cmd_t unc_cmd;
    logic lookup_hit;
    logic line_done;

    // line commands drop bit 31 and the byte offset
    assign refill_cmd = '{read: 1'b1, single: 1'b0,
                          addr: {1'b0, req.tag, req.index, {`DC_OFFSET_W{1'b0}}},
                          wline: victim_line, wdata: req.wdata, strb: 4'hf};
    assign wb_cmd = '{read: 1'b0, single: 1'b0,
                      addr: {1'b0, victim_tag, req.index, {`DC_OFFSET_W{1'b0}}},
                      wline: victim_line, wdata: req.wdata, strb: 4'hf};
    assign unc_cmd = '{read: !req.write, single: 1'b1,
                       addr: {1'b0, req.addr[30:0]},
                       wline: victim_line, wdata: req.wdata, strb: req.strb};

    always_comb begin
        state_d = state_q;
        cmd_go = 1'b0;
        cmd = refill_cmd;
        case (state_q)
            IDLE: begin
                if (req_go && req.uncached) begin
                    cmd_go = 1'b1;
                    cmd = unc_cmd;
                    state_d = UNCACHED;
                end else if (req_go) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    cmd_go = 1'b1;
                    cmd = wb_cmd;
                    state_d = WRITE_BACK;
                end else begin
                    cmd_go = 1'b1;  // clean victim, straight to refill
                    state_d = REFILL;
                end
            end
            WRITE_BACK: begin
                if (cmd_done) begin
                    cmd_go = 1'b1;
                    state_d = REFILL;
                end
            end
            REFILL, UNCACHED: begin
                if (cmd_done) state_d = RESPOND;
            end
            default: state_d = IDLE;  // RESPOND
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // requested word of a refill, or the single uncached beat
    always_ff @(posedge clk) begin
        if (beat_valid && (req.uncached || beat_num == req.word_sel)) begin
            rdata_q <= beat_data;
        end
    end

    assign lookup_hit = (state_q == LOOKUP) && hit;
    assign line_done = (state_q == RESPOND) && !req.uncached; // refilled line now hits

    assign busy = req_go || (state_q != IDLE);
    assign rsp_valid = lookup_hit || (state_q == RESPOND);
    assign rsp_rdata = (state_q == RESPOND) ? rdata_q : hit_line[req.word_sel];

    assign index = req.index;
    assign tag = req.tag;

    assign fill_en = (state_q == REFILL) && beat_valid;
    assign fill_word = beat_num;
    assign fill_data = beat_data;
    assign fill_way = victim_way;

    // store merge lands after the fill has completed
    assign touch_en = lookup_hit || line_done;
    assign touch_way = hit_way;
    assign store_en = req.write && touch_en;
    assign store_way = hit_way;
    assign store_word = req.word_sel;
    assign store_data = req.wdata;
    assign store_strb = req.strb;

endmodule

// ==== logic/mem_burst_port.sv ====
`timescale 1ns/1ps
`include "dcache_consts.svh"

module mem_burst_port (
    input logic clk,
    input logic rst,
    input logic cmd_go,
    input dcache_pkg::bus_cmd_t cmd,
    output dcache_pkg::addr_t araddr,
    output logic [7:0] arlen,
    output logic arvalid,
    input logic arready,
    input dcache_pkg::word_t rdata,
    input logic rlast,
    input logic rvalid,
    output logic rready,
    output dcache_pkg::addr_t awaddr,
    output logic [7:0] awlen,
    output logic awvalid,
    input logic awready,
    output dcache_pkg::word_t wdata,
    output dcache_pkg::strb_t wstrb,
    output logic wlast,
    output logic wvalid,
    input logic wready,
    input logic bvalid,
    output logic bready,
    output logic beat_valid,
    output dcache_pkg::word_sel_t beat_num,
    output dcache_pkg::word_t beat_data,
    output logic cmd_done
);
    import dcache_pkg::*;

    bus_cmd_t cmd_q;
    word_sel_t cnt_q;  // beat within the burst
    logic r_beat;
    logic w_beat;
    logic [7:0] len;

    assign r_beat = rvalid && rready;
    assign w_beat = wvalid && wready;
    assign len = cmd_q.single ? 8'd0 : 8'(`DC_BURST_LEN);

    assign araddr = cmd_q.addr;
    assign arlen = len;
    assign awaddr = cmd_q.addr;
    assign awlen = len;
    assign wdata = cmd_q.single ? cmd_q.wdata : cmd_q.wline[cnt_q];
    assign wstrb = cmd_q.strb;
    assign wlast = cmd_q.single || (cnt_q == word_sel_t'(`DC_BURST_LEN));

    assign beat_valid = r_beat;
    assign beat_num = cnt_q;
    assign beat_data = rdata;
    assign cmd_done = (r_beat && rlast) || (bvalid && bready);

    always_ff @(posedge clk) begin
        if (cmd_go) begin
            cmd_q <= cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            rready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            cnt_q <= '0;
        end else if (cmd_go) begin
            arvalid <= cmd.read;
            rready <= cmd.read;  // data can't arrive before the address
            awvalid <= !cmd.read;
            bready <= 1'b0;  // write-back response may end in this cycle
            cnt_q <= '0;
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
            end
            if (r_beat) begin
                cnt_q <= cnt_q + 1'b1;
                if (rlast) rready <= 1'b0;
            end
            // write data follows an accepted address
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                wvalid <= 1'b1;
            end
            if (w_beat) begin
                cnt_q <= cnt_q + 1'b1;
                if (wlast) begin
                    wvalid <= 1'b0;
                    bready <= 1'b1;
                end
            end
            if (bvalid && bready) begin
                bready <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/dcache_top.sv ====
`timescale 1ns/1ps

module dcache_top (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic req_write,
    input dcache_pkg::addr_t req_addr,
    input dcache_pkg::word_t req_wdata,
    input dcache_pkg::strb_t req_strb,
    output logic busy,
    output logic rsp_valid,
    output dcache_pkg::word_t rsp_rdata,
    output dcache_pkg::addr_t araddr,
    output logic [7:0] arlen,
    output logic arvalid,
    input logic arready,
    input dcache_pkg::word_t rdata,
    input logic rlast,
    input logic rvalid,
    output logic rready,
    output dcache_pkg::addr_t awaddr,
    output logic [7:0] awlen,
    output logic awvalid,
    input logic awready,
    output dcache_pkg::word_t wdata,
    output dcache_pkg::strb_t wstrb,
    output logic wlast,
    output logic wvalid,
    input logic wready,
    input logic bvalid,
    output logic bready
);
    import dcache_pkg::*;

    logic req_go;
    cpu_req_t req;
    index_t index;
    tag_t tag;
    logic hit;
    way_t hit_way;
    line_t hit_line;
    way_t victim_way;
    logic victim_dirty;
    tag_t victim_tag;
    line_t victim_line;
    logic fill_en;
    word_sel_t fill_word;
    word_t fill_data;
    way_t fill_way;
    logic store_en;
    word_sel_t store_word;
    word_t store_data;
    strb_t store_strb;
    way_t store_way;
    logic touch_en;
    way_t touch_way;
    logic cmd_go;
    bus_cmd_t cmd;
    logic cmd_done;
    logic beat_valid;
    word_sel_t beat_num;
    word_t beat_data;

    cpu_req_capture cpu_req_capture_i (
        .clk, .rst, .req_valid, .req_write, .req_addr, .req_wdata, .req_strb,
        .req_go, .req
    );

    dcache_ctrl dcache_ctrl_i (
        .clk, .rst, .req_go, .req,
        .hit, .hit_way, .hit_line, .victim_way, .victim_dirty, .victim_tag, .victim_line,
        .cmd_done, .beat_valid, .beat_num, .beat_data,
        .busy, .rsp_valid, .rsp_rdata, .index, .tag,
        .fill_en, .fill_word, .fill_data, .fill_way,
        .store_en, .store_word, .store_data, .store_strb, .store_way,
        .touch_en, .touch_way, .cmd_go, .cmd
    );

    dcache_arrays dcache_arrays_i (
        .clk, .rst, .index, .tag,
        .fill_en, .fill_word, .fill_data, .fill_way,
        .store_en, .store_word, .store_data, .store_strb, .store_way,
        .touch_en, .touch_way,
        .hit, .hit_way, .hit_line, .victim_way, .victim_dirty, .victim_tag, .victim_line
    );

    mem_burst_port mem_burst_port_i (
        .clk, .rst, .cmd_go, .cmd,
        .araddr, .arlen, .arvalid, .arready,
        .rdata, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awvalid, .awready,
        .wdata, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready,
        .beat_valid, .beat_num, .beat_data, .cmd_done
    );

endmodule

// ==== tests/mem_model.sv ====
`timescale 1ns/1ps

module mem_model #(
    parameter dcache_pkg::word_t fill_key = 32'ha5a5_0000
) (
    input logic clk,
    input logic rst,
    input dcache_pkg::addr_t araddr,
    input logic [7:0] arlen,
    input logic arvalid,
    output logic arready,
    output dcache_pkg::word_t rdata,
    output logic rlast,
    output logic rvalid,
    input logic rready,
    input dcache_pkg::addr_t awaddr,
    input logic [7:0] awlen,
    input logic awvalid,
    output logic awready,
    input dcache_pkg::word_t wdata,
    input dcache_pkg::strb_t wstrb,
    input logic wlast,
    input logic wvalid,
    output logic wready,
    output logic bvalid,
    input logic bready,
    output int rd_bursts,
    output int wr_bursts,
    output int singles,
    output logic last_was_read
);
    import dcache_pkg::*;

    word_t mem [addr_t];  // only written words are held here
    addr_t r_addr;
    addr_t w_addr;
    logic [7:0] r_len;
    logic [7:0] r_cnt;
    logic [7:0] w_cnt;
    logic r_active;
    logic b_pend;  // last write beat taken, response still owed

    function automatic addr_t word_addr(addr_t a);
        return {a[31:2], 2'b00};
    endfunction

    // untouched words read back as address xor key
    function automatic word_t read_word(addr_t a);
        return mem.exists(word_addr(a)) ? mem[word_addr(a)] : (word_addr(a) ^ fill_key);
    endfunction

    function automatic word_t merge_word(word_t old, word_t nw, strb_t s);
        word_t m;
        m = old;
        for (int b = 0; b < 4; b++) begin
            if (s[b]) m[8*b +: 8] = nw[8*b +: 8];
        end
        return m;
    endfunction

    function automatic logic random_ready();
        return ($urandom % 4) != 0;  // high three cycles in four
    endfunction

    initial begin
        void'($urandom(32'h8f78_d5bd));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            awready <= 1'b0;
            wready <= 1'b0;
            rvalid <= 1'b0;
            rlast <= 1'b0;
            rdata <= '0;
            bvalid <= 1'b0;
            r_active <= 1'b0;
            b_pend <= 1'b0;
            rd_bursts <= 0;
            wr_bursts <= 0;
            singles <= 0;
            last_was_read <= 1'b0;
        end else begin
            arready <= random_ready();
            awready <= random_ready();
            wready <= random_ready();
            if (arvalid && arready) begin
                r_addr <= araddr;
                r_len <= arlen;
                r_cnt <= 8'd0;
                r_active <= 1'b1;
                last_was_read <= 1'b1;
                if (arlen == 8'd0) singles <= singles + 1;
                else rd_bursts <= rd_bursts + 1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                r_cnt <= r_cnt + 8'd1;
                if (rlast) r_active <= 1'b0;
            end else if (r_active && !rvalid && random_ready()) begin
                rvalid <= 1'b1;
                rdata <= read_word(r_addr + addr_t'({r_cnt, 2'b00}));
                rlast <= (r_cnt == r_len);
            end
            if (awvalid && awready) begin
                w_addr <= awaddr;
                w_cnt <= 8'd0;
                last_was_read <= 1'b0;
                if (awlen == 8'd0) singles <= singles + 1;
                else wr_bursts <= wr_bursts + 1;
            end
            if (wvalid && wready) begin
                w_cnt <= w_cnt + 8'd1;
                if (wlast) b_pend <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (b_pend && random_ready()) begin
                bvalid <= 1'b1;
                b_pend <= 1'b0;
            end
        end
    end

    // write beats land in the word store
    always @(posedge clk) begin
        if (!rst && wvalid && wready) begin
            mem[word_addr(w_addr + addr_t'({w_cnt, 2'b00}))] =
                merge_word(read_word(w_addr + addr_t'({w_cnt, 2'b00})), wdata, wstrb);
        end
    end

endmodule

// ==== tests/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam int max_entries = 64;
    localparam word_t fill_key = 32'ha5a5_0000;  // stim expectations assume this key

    logic clk;
    logic rst;
    logic req_valid;
    logic req_write;
    addr_t req_addr;
    word_t req_wdata;
    strb_t req_strb;
    logic busy;
    logic rsp_valid;
    word_t rsp_rdata;
    addr_t araddr;
    logic [7:0] arlen;
    logic arvalid;
    logic arready;
    word_t rdata;
    logic rlast;
    logic rvalid;
    logic rready;
    addr_t awaddr;
    logic [7:0] awlen;
    logic awvalid;
    logic awready;
    word_t wdata;
    strb_t wstrb;
    logic wlast;
    logic wvalid;
    logic wready;
    logic bvalid;
    logic bready;
    int rd_bursts;
    int wr_bursts;
    int singles;
    logic last_was_read;

    logic [31:0] stim_words [max_entries*6];  // six words per access
    int n_entries;
    int cycle_limit = 0;
    int cycle_cnt = 0;
    int n_pass = 0;
    int n_fail = 0;

    dcache_top dcache_top_i (.*);

    mem_model #(.fill_key(fill_key)) backing_mem (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: no finish after %0d cycles", cycle_cnt);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic int count_entries();
        int n;
        n = 0;
        while (n < max_entries && stim_words[n*6] != 32'h0000_000f) n++;  // f ends the list
        return n;
    endfunction

    task automatic run_entry(input int idx);
        word_t op;
        addr_t addr;
        word_t wr_data;
        word_t strb;
        word_t expect_data;
        word_t traffic;
        word_t got;
        int rd0;
        int wr0;
        int sg0;
        int exp_rd;
        int exp_wr;
        int exp_sg;
        int lat;
        bit ok;
        op = stim_words[idx*6];
        addr = stim_words[idx*6+1];
        wr_data = stim_words[idx*6+2];
        strb = stim_words[idx*6+3];
        expect_data = stim_words[idx*6+4];
        traffic = stim_words[idx*6+5];
        ok = 1'b1;
        // bus traffic per class: hit, clean miss, dirty miss, uncached
        exp_rd = (traffic == 32'd1 || traffic == 32'd2) ? 1 : 0;
        exp_wr = (traffic == 32'd2) ? 1 : 0;
        exp_sg = (traffic == 32'd3) ? 1 : 0;
        assert (traffic <= 32'd3) else begin
            ok = 1'b0;
            $display("stimulus entry %0d has an unknown traffic class %0h", idx, traffic);
        end
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        sg0 = singles;
        @(posedge clk);
        #1;
        assert (busy == 1'b0) else begin
            ok = 1'b0;
            $display("ERROR at %0d ns: busy still high when entry %0d is due", $time, idx);
        end
        req_valid = 1'b1;
        req_write = op[0];
        req_addr = addr;
        req_wdata = wr_data;
        req_strb = strb[3:0];
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            // busy covers the cycle after acceptance through the response
            assert (busy == 1'b1) else begin
                ok = 1'b0;
                $display("ERROR at %0d ns: busy low while entry %0d is in flight",
                         $time, idx);
            end
        end while (!rsp_valid);
        got = rsp_rdata;
        if (!op[0]) begin
            assert (got == expect_data) else begin
                ok = 1'b0;
                $display("ERROR at %0d ns: load %h read %h, expected %h",
                         $time, addr, got, expect_data);
            end
        end
        if (traffic == 32'd0) begin
            assert (lat == 2) else begin
                ok = 1'b0;
                $display("ERROR at %0d ns: hit answered after %0d cycles, expected 2",
                         $time, lat);
            end
        end
        assert (rd_bursts - rd0 == exp_rd && wr_bursts - wr0 == exp_wr
                && singles - sg0 == exp_sg) else begin
            ok = 1'b0;
            $display("ERROR at %0d ns: traffic rd %0d wr %0d single %0d, expected %0d %0d %0d",
                     $time, rd_bursts - rd0, wr_bursts - wr0, singles - sg0,
                     exp_rd, exp_wr, exp_sg);
        end
        if (traffic == 32'd2) begin
            assert (last_was_read) else begin
                ok = 1'b0;
                $display("ERROR at %0d ns: refill did not follow the write-back", $time);
            end
        end
        if (ok) n_pass++;
        else n_fail++;
        $display("test %0d %s %h class %0d, %0d cycles: %s", idx,
                 op[0] ? "store" : "load", addr, traffic, lat, ok ? "ok" : "mismatch");
    endtask

    initial begin
        rst = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_strb = '0;
        $readmemh("tests/dcache_stim.txt", stim_words);
        n_entries = count_entries();
        cycle_limit = n_entries * 80 + 100;
        assert (n_entries > 0) else begin
            n_fail++;
            $display("stimulus file tests/dcache_stim.txt holds no entries");
        end
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("tests run %0d, passed %0d, failed %0d", n_entries, n_pass, n_fail);
        if (n_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tests/dcache_stim.txt ====
// op addr wdata strb expected_rdata class
// op 0 load, 1 store, f ends the list; class 0 hit, 1 clean miss, 2 dirty miss, 3 uncached
// memory words start as word address xor a5a50000, bit 31 marks uncached
0 00000114 00000000 f a5a50114 1 // set 1 line A cold miss
0 00000114 00000000 f a5a50114 0
0 0000011c 00000000 f a5a5011c 0
1 00000118 11223344 5 00000000 0 // bytes 0 and 2
0 00000118 00000000 f a5220144 0
1 00000110 deadbeef c 00000000 0 // upper half
0 00000110 00000000 f dead0110 0
0 00000214 00000000 f a5a50214 1 // line B, then A, then C
0 00000110 00000000 f dead0110 0
0 00000318 00000000 f a5a50318 1
0 00000114 00000000 f a5a50114 0
0 00000210 00000000 f a5a50210 1
0 0000031c 00000000 f a5a5031c 2 // dirty A written back
0 80000118 00000000 f a5220144 3
0 80000110 00000000 f dead0110 3
0 00000118 00000000 f a5220144 1
1 00000424 0badf00d f 00000000 1 // set 2 store miss allocates
0 00000424 00000000 f 0badf00d 0
0 00000520 00000000 f a5a50520 1
0 00000628 00000000 f a5a50628 2
0 80000424 00000000 f 0badf00d 3
1 80000914 12345678 3 00000000 3 // uncached store into set 1
0 80000914 00000000 f a5a55678 3
0 00000310 00000000 f a5a50310 0
0 00000110 00000000 f dead0110 0
0 00000914 00000000 f a5a55678 1
f 00000000 00000000 0 00000000 0

// ==== tb.f ====
+incdir+include
logic/dcache_pkg.sv
logic/cpu_req_capture.sv
logic/dcache_arrays.sv
logic/dcache_ctrl.sv
logic/mem_burst_port.sv
logic/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim > sim.log
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
